// File: opn_mmr.f
source/opn_pkg.sv
source/opn_prescaler.sv
source/opn_busy_counter.sv
source/opn_busy_fsm.sv
source/opn_addr_decode.sv
source/opn_global_regs.sv
source/opn_mmr.sv
tb/opn_mmr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the OPN register interface testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module opn_mmr_tb -f opn_mmr.f -o opn_mmr_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/opn_mmr_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

// File: tb/opn_mmr_tb.sv
//**********************************************************************
// OPN host register interface testbench
// Table of bus writes with register, strobe, update-select, busy and
// prescaler checks against values from the register map
//**********************************************************************

module opn_mmr_tb;

    typedef enum logic [3:0] {
        K_NONE, K_TIMER_A, K_TIMER_B, K_CTL, K_FLAGS, K_PCM, K_UPD, K_BUSY, K_DIV
    } kind_t;

    typedef struct packed {
        logic               bank;
        opn_pkg::reg_addr_t regnum;
        opn_pkg::reg_data_t data;      // Replaced by an LFSR byte for K_UPD
        kind_t              kind;
        logic [15:0]        exp;
    } entry_t;

    logic               clk = 1'b0;
    logic               rst, write, table_ready = 1'b0;
    logic [1:0]         addr;
    opn_pkg::reg_data_t din, reg_data;
    opn_pkg::chan_t     up_ch;
    opn_pkg::op_t       up_op;
    opn_pkg::ch_upd_t   up_chreg;
    opn_pkg::op_upd_t   up_opreg;
    opn_pkg::timer_a_t  value_a;
    opn_pkg::timer_b_t  value_b;
    opn_pkg::lfo_freq_t lfo_freq;
    opn_pkg::pcm_t      pcm;
    logic               up_keyon, load_a, load_b, enable_irq_a, enable_irq_b;
    logic               clr_flag_a, clr_flag_b, fast_timers, eg_stop, pg_stop, lfo_en;
    logic               csm, effect, pcm_en, pcm_wr, busy, clk_en;
    logic [31:0]        lfsr_state = 32'hc92e_f37e;
    entry_t             table_q[$];

    opn_mmr opn_mmr_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // Galois form
    endfunction

    task automatic next_byte(output opn_pkg::reg_data_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic stop_on_failure(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic report_mismatch(string what, logic [15:0] got, logic [15:0] exp);
        stop_on_failure($sformatf("** Error at time %0t: %s is %0h, expected %0h",
                                  $time, what, got, exp));
    endtask

    task automatic check_timer(string what, opn_pkg::timer_a_t got, opn_pkg::timer_a_t exp);
        if (got !== exp) report_mismatch(what, 16'(got), 16'(exp));
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) report_mismatch(what, 16'(got), 16'(exp));
    endtask

    task automatic check_pcm(opn_pkg::pcm_t got, opn_pkg::pcm_t exp);
        if (got !== exp) report_mismatch("pcm", 16'(got), 16'(exp));
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) report_mismatch(what, 16'(got), 16'(exp));
    endtask

    task automatic check_updates(opn_pkg::chan_t ch_exp, opn_pkg::op_t op_exp,
                                 opn_pkg::ch_upd_t chreg_exp, opn_pkg::op_upd_t opreg_exp,
                                 opn_pkg::reg_data_t data_exp);
        if (up_ch !== ch_exp) report_mismatch("up_ch", 16'(up_ch), 16'(ch_exp));
        if (up_op !== op_exp) report_mismatch("up_op", 16'(up_op), 16'(op_exp));
        if (up_chreg !== chreg_exp) report_mismatch("up_chreg", 16'(up_chreg), 16'(chreg_exp));
        if (up_opreg !== opreg_exp) report_mismatch("up_opreg", 16'(up_opreg), 16'(opreg_exp));
        if (reg_data !== data_exp) report_mismatch("reg_data", 16'(reg_data), 16'(data_exp));
    endtask

    task automatic check_flags(string what, logic [7:0] got, logic [7:0] exp);
        for (int i = 0; i < 8; i++)
            check_bit($sformatf("%s bit %0d", what, i), got[i], exp[i]);
    endtask

    // Strobes must drop by the next clk_en, at most one ratio-6 period
    task automatic wait_strobes_clear;
        for (int i = 0; i < 7 && (clr_flag_a || clr_flag_b || pcm_wr); i++) next_cycle();
        if (clr_flag_a || clr_flag_b || pcm_wr)
            stop_on_failure("A one-shot strobe stayed high longer than one prescaler period");
    endtask

    task automatic next_pulse(output int gap);
        gap = 0;
        do begin
            next_cycle();
            gap++;
        end while (!clk_en && gap < 16);
        if (!clk_en) stop_on_failure("No clock-enable pulse arrived within 16 cycles");
    endtask

    task automatic check_busy;
        int   pulses;
        logic last_en;
        pulses  = 0;
        last_en = 1'b0;
        check_bit("busy after data write", busy, 1'b1);
        for (int i = 0; i < 400 && busy; i++) begin
            last_en = clk_en;    // Pulse seen here is counted at the next edge
            if (clk_en) pulses++;
            next_cycle();
        end
        check_count("clk_en pulses while busy", pulses, opn_pkg::BUSY_PULSES);
        check_bit("clk_en on last busy cycle", last_en, 1'b1);
    endtask

    task automatic bus_write(logic bank, opn_pkg::reg_addr_t regnum, opn_pkg::reg_data_t data);
        next_cycle();
        write = 1'b1;
        addr  = {bank, 1'b0};    // Port 0 or 2
        din   = regnum;
        next_cycle();
        addr  = {bank, 1'b1};    // Port 1 or 3
        din   = data;
        next_cycle();
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
    endtask

    task automatic add_entry(logic bank, opn_pkg::reg_addr_t regnum, opn_pkg::reg_data_t data,
                             kind_t kind, logic [15:0] exp);
        table_q.push_back('{bank, regnum, data, kind, exp});
    endtask

    // K_CTL exp is {csm, effect, clr_b, clr_a, irq_b, irq_a, load_b, load_a}
    // K_FLAGS exp is {pcm_en, lfo_en, lfo_freq, eg_stop, pg_stop, fast_timers}
    // K_PCM exp is {pcm_wr, pcm}, K_UPD exp is {keyon, chreg, opreg}
    task automatic fill_table;
        add_entry(1'b0, opn_pkg::REG_CLKA1, 8'hA5, K_NONE, 16'h000);
        add_entry(1'b0, opn_pkg::REG_CLKA2, 8'h02, K_TIMER_A, 16'h296);
        add_entry(1'b0, opn_pkg::REG_CLKB, 8'h3C, K_TIMER_B, 16'h03C);
        add_entry(1'b0, opn_pkg::REG_TIMER, 8'hBF, K_CTL, 16'h0FF);
        add_entry(1'b0, opn_pkg::REG_TIMER, 8'h45, K_CTL, 16'h045);
        add_entry(1'b0, opn_pkg::REG_LFO, 8'h0D, K_FLAGS, 16'h068);
        add_entry(1'b0, opn_pkg::REG_TESTYM, 8'h24, K_FLAGS, 16'h06D);
        add_entry(1'b0, opn_pkg::REG_TESTYM, 8'h08, K_FLAGS, 16'h06A);
        add_entry(1'b0, opn_pkg::REG_PCM, 8'h5A, K_PCM, 16'h3B5);
        add_entry(1'b0, opn_pkg::REG_DACTEST, 8'h00, K_PCM, 16'h1B4);
        add_entry(1'b0, opn_pkg::REG_DACTEST, 8'h08, K_PCM, 16'h1B5);
        add_entry(1'b0, opn_pkg::REG_PCM_EN, 8'h80, K_FLAGS, 16'h0EA);
        add_entry(1'b0, 8'h30, 8'h00, K_UPD, 16'h001);
        add_entry(1'b1, 8'h45, 8'h00, K_UPD, 16'h002);
        add_entry(1'b0, 8'h5A, 8'h00, K_UPD, 16'h004);
        add_entry(1'b1, 8'h6E, 8'h00, K_UPD, 16'h008);
        add_entry(1'b0, 8'h72, 8'h00, K_UPD, 16'h010);
        add_entry(1'b1, 8'h89, 8'h00, K_UPD, 16'h020);
        add_entry(1'b0, 8'h96, 8'h00, K_UPD, 16'h040);
        add_entry(1'b1, 8'hA1, 8'h00, K_UPD, 16'h080);
        add_entry(1'b0, 8'hB2, 8'h00, K_UPD, 16'h100);
        add_entry(1'b1, 8'hB6, 8'h00, K_UPD, 16'h200);
        add_entry(1'b0, 8'h33, 8'h00, K_UPD, 16'h000);    // Slot 3 is unused
        add_entry(1'b1, 8'hB7, 8'h00, K_UPD, 16'h000);
        add_entry(1'b0, opn_pkg::REG_KON, 8'h00, K_UPD, 16'h400);
        add_entry(1'b0, opn_pkg::REG_CLKB, 8'h11, K_BUSY, 16'h000);
        add_entry(1'b0, opn_pkg::REG_CLK_N2, 8'h00, K_DIV, 16'd2);
        add_entry(1'b0, opn_pkg::REG_CLKB, 8'h22, K_BUSY, 16'h000);
        add_entry(1'b0, opn_pkg::REG_CLK_N3, 8'h00, K_DIV, 16'd3);
        add_entry(1'b0, opn_pkg::REG_CLK_N6, 8'h00, K_DIV, 16'd6);
    endtask

    initial begin
        wait (table_ready);
        #(table_q.size() * 400 + 4000);
        stop_on_failure("Run hung: the watchdog expired before the table finished");
    end

    initial begin
        entry_t             e;
        opn_pkg::reg_data_t d;
        int                 gap;
        rst   = 1'b1;
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
        fill_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        check_flags("reset state", {busy, clr_flag_a, clr_flag_b, pcm_wr, up_keyon, load_a,
                                    enable_irq_a, pcm_en}, 8'h00);
        check_flags("reset loads and selects", {4'h0, load_b, enable_irq_b, |up_chreg,
                                                |up_opreg}, 8'h00);
        next_pulse(gap);
        next_pulse(gap);
        check_count("clk_en spacing after reset", gap, 6);
        foreach (table_q[i]) begin
            e = table_q[i];
            d = e.data;
            if (e.kind == K_UPD) next_byte(d);
            bus_write(e.bank, e.regnum, d);
            case (e.kind)
                K_TIMER_A: check_timer("value_a", value_a, e.exp[9:0]);
                K_TIMER_B: check_timer("value_b", opn_pkg::timer_a_t'(value_b), e.exp[9:0]);
                K_CTL: begin
                    check_flags("timer control", {csm, effect, clr_flag_b, clr_flag_a,
                                enable_irq_b, enable_irq_a, load_b, load_a}, e.exp[7:0]);
                    wait_strobes_clear();
                end
                K_FLAGS: check_flags("mode flags", {pcm_en, lfo_en, lfo_freq, eg_stop,
                                     pg_stop, fast_timers}, e.exp[7:0]);
                K_PCM: begin
                    check_pcm(pcm, e.exp[8:0]);
                    check_bit("pcm_wr", pcm_wr, e.exp[9]);
                    wait_strobes_clear();
                end
                K_UPD: begin
                    check_updates({e.bank, e.regnum[1:0]}, e.regnum[3:2], e.exp[9:7],
                                  e.exp[6:0], d);
                    check_bit("up_keyon", up_keyon, e.exp[10]);
                end
                K_BUSY: check_busy();
                K_DIV: begin
                    next_pulse(gap);    // May still span the divider change
                    next_pulse(gap);
                    check_count("clk_en spacing", gap, int'(e.exp));
                end
                default: ;
            endcase
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: source/opn_mmr.sv
//**********************************************************************
// OPN host register interface
// Top level joining the address decoder, global registers, prescaler
// and busy logic
//**********************************************************************

module opn_mmr (
    input  logic               clk,
    input  logic               rst,
    input  logic               write,
    input  logic [1:0]         addr,
    input  opn_pkg::reg_data_t din,
    // Voice register file side
    output opn_pkg::reg_data_t reg_data,
    output opn_pkg::chan_t     up_ch,
    output opn_pkg::op_t       up_op,
    output logic               up_keyon,
    output opn_pkg::ch_upd_t   up_chreg,
    output opn_pkg::op_upd_t   up_opreg,
    // Timers
    output opn_pkg::timer_a_t  value_a,
    output opn_pkg::timer_b_t  value_b,
    output logic               load_a,
    output logic               load_b,
    output logic               enable_irq_a,
    output logic               enable_irq_b,
    output logic               clr_flag_a,
    output logic               clr_flag_b,
    output logic               fast_timers,
    // Test, LFO and channel 3 mode
    output logic               eg_stop,
    output logic               pg_stop,
    output logic               lfo_en,
    output opn_pkg::lfo_freq_t lfo_freq,
    output logic               csm,
    output logic               effect,
    // DAC
    output opn_pkg::pcm_t      pcm,
    output logic               pcm_en,
    output logic               pcm_wr,
    output logic               busy,
    output logic               clk_en
);

    logic               reg_wr;
    opn_pkg::reg_addr_t sel_reg;
    opn_pkg::div_sel_t  div_sel;
    logic               busy_run;
    logic               busy_last;

    // Port names match the nets above
    opn_addr_decode  addr_decode_inst  (.*);
    opn_global_regs  global_regs_inst  (.*);
    opn_prescaler    prescaler_inst    (.*);
    opn_busy_fsm     busy_fsm_inst     (.*);
    opn_busy_counter busy_counter_inst (.*);

endmodule

// File: source/opn_global_regs.sv
//**********************************************************************
// OPN global registers
// Timer, LFO, test, DAC and prescaler settings written by data
// writes, with one-shot strobes cleared on the clock enable
//**********************************************************************

module opn_global_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               clk_en,
    input  logic               reg_wr,
    input  opn_pkg::reg_addr_t sel_reg,
    input  opn_pkg::reg_data_t din,
    output opn_pkg::timer_a_t  value_a,
    output opn_pkg::timer_b_t  value_b,
    output logic               load_a,
    output logic               load_b,
    output logic               enable_irq_a,
    output logic               enable_irq_b,
    output logic               clr_flag_a,
    output logic               clr_flag_b,
    output logic               fast_timers,
    output logic               eg_stop,
    output logic               pg_stop,
    output logic               lfo_en,
    output opn_pkg::lfo_freq_t lfo_freq,
    output logic               csm,
    output logic               effect,
    output opn_pkg::pcm_t      pcm,
    output logic               pcm_en,
    output logic               pcm_wr,
    output opn_pkg::div_sel_t  div_sel
);

    // Timer reloads, LFO rate and DAC sample
    always_ff @(posedge clk) begin
        if (reg_wr) begin
            case (sel_reg)
                opn_pkg::REG_CLKA1:   value_a[9:2] <= din;
                opn_pkg::REG_CLKA2:   value_a[1:0] <= din[1:0];
                opn_pkg::REG_CLKB:    value_b      <= din;
                opn_pkg::REG_LFO:     lfo_freq     <= din[2:0];
                opn_pkg::REG_PCM:     pcm          <= {~din[7], din[6:0], 1'b1};
                opn_pkg::REG_DACTEST: pcm[0]       <= din[3];
                default:              ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            fast_timers  <= 1'b0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            lfo_en       <= 1'b0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
            div_sel      <= opn_pkg::DIV_RESET;
        end else if (reg_wr) begin
            case (sel_reg)
                opn_pkg::REG_TESTYM: begin
                    eg_stop     <= din[5];
                    pg_stop     <= din[3];
                    fast_timers <= din[2];
                end
                opn_pkg::REG_LFO:    lfo_en <= din[3];
                opn_pkg::REG_TIMER: begin
                    effect <= |din[7:6];
                    csm    <= din[7:6] == 2'b10;    // CSM only, not effect mode
                    {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                        load_b, load_a} <= din[5:0];
                end
                opn_pkg::REG_PCM:    pcm_wr <= 1'b1;
                opn_pkg::REG_PCM_EN: pcm_en <= din[7];
                opn_pkg::REG_CLK_N6: div_sel[1] <= 1'b1;
                opn_pkg::REG_CLK_N3: div_sel[0] <= 1'b1;
                opn_pkg::REG_CLK_N2: div_sel <= '0;
                default:             ;
            endcase
        end else if (clk_en) begin
            // One-shot strobes last until the next synthesis pulse
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
        end
    end

endmodule

// File: source/opn_addr_decode.sv
//**********************************************************************
// OPN address decoder
// Latches the register number and bank from address writes and turns
// data writes into channel, operator and key-on update selects
//**********************************************************************

module opn_addr_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               write,
    input  logic [1:0]         addr,
    input  opn_pkg::reg_data_t din,
    output logic               reg_wr,
    output opn_pkg::reg_addr_t sel_reg,
    output opn_pkg::reg_data_t reg_data,
    output opn_pkg::chan_t     up_ch,
    output opn_pkg::op_t       up_op,
    output logic               up_keyon,
    output opn_pkg::ch_upd_t   up_chreg,
    output opn_pkg::op_upd_t   up_opreg
);

    logic              bank;      // Upper channel bank from port 2
    opn_pkg::ch_upd_t  ch_sel;
    opn_pkg::op_upd_t  op_sel;

    assign reg_wr = write & addr[0];    // Ports 1 and 3

    // Register number latch
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            bank    <= 1'b0;
        end else if (write && !addr[0]) begin
            sel_reg <= din;
            bank    <= addr[1];
        end
    end

    // Slot 3 of every group is unused
    always_comb begin
        ch_sel = '0;
        op_sel = '0;
        if (sel_reg[1:0] != 2'b11) begin
            casez (sel_reg)
                8'b1010_00??: ch_sel = 3'b001;    // Frequency low
                8'b1011_00??: ch_sel = 3'b010;    // Feedback and algorithm
                8'b1011_01??: ch_sel = 3'b100;    // Modulation sensitivity
                8'h3?:        op_sel = 7'b000_0001;
                8'h4?:        op_sel = 7'b000_0010;
                8'h5?:        op_sel = 7'b000_0100;
                8'h6?:        op_sel = 7'b000_1000;
                8'h7?:        op_sel = 7'b001_0000;
                8'h8?:        op_sel = 7'b010_0000;
                8'h9?:        op_sel = 7'b100_0000;    // SSG envelope
                default:      ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr) begin
            reg_data <= din;
            up_ch    <= {bank, sel_reg[1:0]};
            up_op    <= sel_reg[3:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_keyon <= 1'b0;
            up_chreg <= '0;
            up_opreg <= '0;
        end else if (reg_wr) begin
            up_keyon <= sel_reg == opn_pkg::REG_KON;
            up_chreg <= ch_sel;
            up_opreg <= op_sel;
        end
    end

endmodule

// File: source/opn_busy_fsm.sv
//**********************************************************************
// OPN busy state machine
// Raises busy on each new data write and drops it when the busy
// counter reports the last clock-enable pulse
//**********************************************************************

module opn_busy_fsm (
    input  logic clk,
    input  logic rst,
    input  logic reg_wr,
    input  logic busy_last,
    output logic busy,
    output logic busy_run
);

    opn_pkg::busy_state_t state;
    opn_pkg::busy_state_t state_nxt;
    logic                 reg_wr_q;
    logic                 start;

    // Rising edge of the data write strobe
    assign start    = reg_wr & ~reg_wr_q;
    assign busy_run = start;                      // Clears the counter
    assign busy     = state == opn_pkg::BUSY_ACTIVE;

    always_comb begin
        state_nxt = state;
        case (state)
            opn_pkg::BUSY_IDLE:   if (start) state_nxt = opn_pkg::BUSY_ACTIVE;
            opn_pkg::BUSY_ACTIVE: if (!start && busy_last) state_nxt = opn_pkg::BUSY_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= opn_pkg::BUSY_IDLE;
            reg_wr_q <= 1'b0;
        end else begin
            state    <= state_nxt;
            reg_wr_q <= reg_wr;
        end
    end

endmodule

// File: source/opn_busy_counter.sv
//**********************************************************************
// OPN busy counter
// Counts clock-enable pulses after each start and flags the pulse
// that completes the busy period
//**********************************************************************

module opn_busy_counter (
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic busy_run,
    output logic busy_last
);

    opn_pkg::busy_cnt_t cnt;

    assign busy_last = clk_en && (cnt == opn_pkg::busy_cnt_t'(opn_pkg::BUSY_PULSES - 1));

    always_ff @(posedge clk) begin
        if (rst || busy_run) begin
            cnt <= '0;
        end else if (clk_en) begin
            cnt <= cnt + 1'b1;    // Wraps after the last pulse
        end
    end

endmodule

// File: source/opn_prescaler.sv
//**********************************************************************
// OPN prescaler
// Divides clk by 2, 3 or 6 and emits a one-cycle clock-enable pulse
// for the synthesis logic
//**********************************************************************

module opn_prescaler (
    input  logic              clk,
    input  logic              rst,
    input  opn_pkg::div_sel_t div_sel,
    output logic              clk_en
);

    logic [opn_pkg::DIV_CNT_W-1:0] cnt;
    logic [opn_pkg::DIV_CNT_W-1:0] last;    // Final count of the period

    assign last = opn_pkg::DIV_RATIO[div_sel] - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            clk_en <= 1'b0;
        end else if (cnt >= last) begin    // Also catches a shorter ratio
            cnt    <= '0;
            clk_en <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            clk_en <= 1'b0;
        end
    end

endmodule

// File: source/opn_pkg.sv
//**********************************************************************
// OPN register interface package
// Register numbers, field widths, prescaler ratios and busy length
// shared by every block of the host register interface
//**********************************************************************

package opn_pkg;

    typedef logic [7:0] reg_addr_t;    // Latched register number
    typedef logic [7:0] reg_data_t;    // Host data byte
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;
    typedef logic [8:0] pcm_t;         // DAC sample, offset binary plus LSB
    typedef logic [2:0] lfo_freq_t;
    typedef logic [2:0] chan_t;        // Bank in the top bit
    typedef logic [1:0] op_t;
    typedef logic [2:0] ch_upd_t;      // One-hot channel register select
    typedef logic [6:0] op_upd_t;      // One-hot operator register select
    typedef logic [1:0] div_sel_t;
    typedef logic [4:0] busy_cnt_t;

    typedef enum logic {
        BUSY_IDLE   = 1'b0,
        BUSY_ACTIVE = 1'b1
    } busy_state_t;

    // Global register map
    localparam reg_addr_t REG_TESTYM  = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;
    localparam reg_addr_t REG_CLKA2   = 8'h25;
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;

    localparam int BUSY_PULSES = 32;   // Synthesis clock pulses per write

    localparam div_sel_t DIV_RESET = 2'd3;
    localparam int       DIV_CNT_W = 3;

    // Divide ratio per setting, setting 0 in the low slot
    localparam logic [3:0][DIV_CNT_W-1:0] DIV_RATIO = {3'd6, 3'd6, 3'd3, 3'd2};

endpackage
